/* tb.f */
hdl/rv_isa_pkg.sv
hdl/rv_pipe_pkg.sv
hdl/pipe_reg.sv
hdl/reg_file.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_result.sv
hdl/rv_ex_top.sv
tests/rv_ex_sva.sv
tests/tb_rv_ex.sv

/* Bender.yml */
package:
  name: rv_ex

sources:
  - hdl/rv_isa_pkg.sv
  - hdl/rv_pipe_pkg.sv
  - hdl/pipe_reg.sv
  - hdl/reg_file.sv
  - hdl/rv_decode.sv
  - hdl/rv_execute.sv
  - hdl/rv_result.sv
  - hdl/rv_ex_top.sv
  - target: test
    files:
      - tests/rv_ex_sva.sv
      - tests/tb_rv_ex.sv

/* tests/tb_rv_ex.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_ex;

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    localparam int NREGS         = 32;
    localparam int CLK_NS        = 4;
    localparam int RESET_CYCLES  = 8;
    // upper bound on instructions sent by all tests together
    localparam int TEST_INSTRS   = 320;
    localparam int CYC_PER_INSTR = 8;

    logic            clk;
    logic            rst_n;
    logic            instr_valid;
    logic            instr_ready;
    logic [XLEN-1:0] instr;
    logic            res_valid;
    logic            res_ready;
    res_t            res;

    logic [31:0]     lfsr_q;
    logic [XLEN-1:0] shadow [NREGS];
    logic [XLEN-1:0] prog_q [$];
    res_t            exp_q [$];
    int              arr_q [$];
    int              sent_q [$];
    int              in_flight;
    int              cycle_cnt;
    logic            bp_en;

    rv_ex_top #(
        .NREGS (NREGS)
    ) u_rv_ex_top (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .instr_valid_i (instr_valid),
        .instr_ready_o (instr_ready),
        .instr_i       (instr),
        .res_valid_o   (res_valid),
        .res_ready_i   (res_ready),
        .res_o         (res)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_res(input string name, input res_t got, input res_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL t=%0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    // taps 32, 22, 2, 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w = {w[30:0], next_bit()};
        end
        return w;
    endfunction

    function automatic logic [4:0] pick_reg();
        logic [4:0] r;
        r = 5'(rand_bits(5));
        if (r == 5'd0) begin
            r = 5'd1;
        end
        return r;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OP_IMM};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OP_LUI};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [XLEN-1:0] ref_alu(input logic [2:0] f3, input logic alt,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        logic [XLEN-1:0] y;
        case (f3)
            3'd0: y = alt ? a - b : a + b;
            3'd1: y = a << b[4:0];
            3'd2: y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: y = (a < b) ? 32'd1 : 32'd0;
            3'd4: y = a ^ b;
            3'd5: begin
                if (alt) begin
                    y = $unsigned($signed(a) >>> b[4:0]);
                end else begin
                    y = a >> b[4:0];
                end
            end
            3'd6: y = a | b;
            default: y = a & b;
        endcase
        return y;
    endfunction

    // reference model stepped once per instruction in program order
    function automatic res_t ref_step(input logic [31:0] w);
        res_t            r;
        logic [4:0]      rd;
        logic [2:0]      f3;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] addr;
        rd = w[11:7];
        f3 = w[14:12];
        a = shadow[w[19:15]];
        b = shadow[w[24:20]];
        r = '0;
        r.kind = KIND_NOP;
        case (w[6:0])
            OP_REG: begin
                r.kind  = KIND_REG;
                r.rd    = rd;
                r.value = ref_alu(f3, w[30], a, b);
            end
            OP_IMM: begin
                r.kind  = KIND_REG;
                r.rd    = rd;
                r.value = ref_alu(f3, w[30] && f3 == 3'd5, a, {{20{w[31]}}, w[31:20]});
            end
            OP_LUI: begin
                r.kind  = KIND_REG;
                r.rd    = rd;
                r.value = {w[31:12], 12'h000};
            end
            OP_STORE: begin
                if (f3 <= 3'd2) begin
                    addr    = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    r.kind  = KIND_STORE;
                    r.value = addr;
                    if (f3 == 3'd0) begin
                        r.byte_en    = 4'b0001 << addr[1:0];
                        r.store_data = b << (addr[1:0] * 8);
                    end else if (f3 == 3'd1) begin
                        r.byte_en    = addr[1] ? 4'b1100 : 4'b0011;
                        r.store_data = addr[1] ? b << 16 : b;
                    end else begin
                        r.byte_en    = 4'b1111;
                        r.store_data = b;
                    end
                end
            end
            default: ;
        endcase
        if (r.kind == KIND_REG && rd != 5'd0) begin
            shadow[rd] = r.value;
        end
        return r;
    endfunction

    task automatic emit(input logic [31:0] w);
        prog_q.push_back(w);
        exp_q.push_back(ref_step(w));
    endtask

    task automatic emit_rr(input logic [2:0] f3, input logic alt);
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        rd = pick_reg();
        rs1 = pick_reg();
        rs2 = pick_reg();
        emit(enc_r(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd));
    endtask

    task automatic emit_ri(input logic [2:0] f3, input logic alt);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [11:0] imm;
        rd = pick_reg();
        rs1 = pick_reg();
        // shifts carry only shamt and the sra bit
        if (f3 == 3'd1 || f3 == 3'd5) begin
            imm = {alt ? 7'h20 : 7'h00, 5'(rand_bits(5))};
        end else begin
            imm = 12'(rand_bits(12));
        end
        emit(enc_i(imm, rs1, f3, rd));
    endtask

    // send the queued program, then wait for every record
    task automatic run_prog();
        while (prog_q.size() != 0) begin
            instr_valid <= 1'b1;
            instr <= prog_q.pop_front();
            @(posedge clk);
            while (!instr_ready) begin
                @(posedge clk);
            end
        end
        instr_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic dump_regs();
        for (int r = 1; r < NREGS; r++) begin
            emit(enc_i(12'h000, 5'(r), 3'd0, 5'(r)));
        end
        run_prog();
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (u_rv_ex_top.u_sva.n_fail != 0) begin
            abort_run("a bound assertion on the DUT failed");
        end else if (rst_n) begin
            // two in flight fill both pipeline registers
            check_bit("instr_ready_o", instr_ready, in_flight < 2 || res_ready);
            if (instr_valid && instr_ready) begin
                sent_q.push_back(cycle_cnt);
                in_flight = in_flight + 1;
            end
            if (res_valid && res_ready) begin
                if (exp_q.size() == 0) begin
                    abort_run("a record arrived when none was expected");
                end else begin
                    check_res("res_o", res, exp_q.pop_front());
                    arr_q.push_back(cycle_cnt);
                    in_flight = in_flight - 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (bp_en) begin
            res_ready <= next_bit();
        end
    end

    task automatic reset_dut();
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            check_bit("res_valid_o", res_valid, 1'b0);
        end
        rst_n <= 1'b1;
        repeat (4) begin
            @(posedge clk);
            check_bit("res_valid_o", res_valid, 1'b0);
        end
    endtask

    task automatic test_alu_ops();
        for (int r = 1; r < NREGS; r++) begin
            emit(enc_u(20'(rand_bits(20)), 5'(r)));
            emit(enc_i(12'(rand_bits(12)), 5'(r), 3'd0, 5'(r)));
        end
        run_prog();
        for (int rep = 0; rep < 2; rep++) begin
            for (int f = 0; f < 8; f++) begin
                emit_rr(3'(f), 1'b0);
                emit_ri(3'(f), 1'b0);
                if (f == 0 || f == 5) begin
                    emit_rr(3'(f), 1'b1);
                end
                if (f == 5) begin
                    emit_ri(3'(f), 1'b1);
                end
            end
        end
        run_prog();
    endtask

    task automatic test_dependency();
        for (int d = 1; d <= 3; d++) begin
            for (int rep = 0; rep < 4; rep++) begin
                emit(enc_i(12'(rand_bits(12)), 5'd10, 3'd0, 5'd10));
                for (int k = 1; k < d; k++) begin
                    emit(enc_i(12'(rand_bits(12)), 5'd21, 3'd4, 5'(20 + k)));
                end
                // consumer reads x10 on either operand
                if (rep % 2 == 1) begin
                    emit(enc_r(7'h20, 5'd10, 5'd9, 3'd0, 5'd11));
                end else begin
                    emit(enc_r(7'h00, 5'd9, 5'd10, 3'd0, 5'd11));
                end
            end
        end
        run_prog();
    endtask

    task automatic store_case(input logic [2:0] f3, input logic [1:0] offs);
        // base from lui has clear low bits, so offs is the address offset
        emit(enc_u(20'(rand_bits(20)), 5'd12));
        emit(enc_u(20'(rand_bits(20)), 5'd13));
        emit(enc_i(12'(rand_bits(12)), 5'd13, 3'd0, 5'd13));
        emit(enc_s({10'(rand_bits(10)), offs}, 5'd13, 5'd12, f3));
    endtask

    task automatic test_stores();
        for (int o = 0; o < 4; o++) begin
            store_case(F3_SB, 2'(o));
        end
        store_case(F3_SH, 2'd0);
        store_case(F3_SH, 2'd2);
        store_case(F3_SW, 2'd0);
        run_prog();
        dump_regs();
    endtask

    task automatic test_backpressure();
        logic [2:0] f3;
        for (int i = 0; i < 40; i++) begin
            f3 = 3'(rand_bits(3));
            case (rand_bits(2))
                0: emit_rr(f3, (f3 == 3'd0 || f3 == 3'd5) && next_bit());
                1: emit_ri(f3, f3 == 3'd5 && next_bit());
                2: emit(enc_u(20'(rand_bits(20)), pick_reg()));
                default: emit(enc_s(12'(rand_bits(12)), pick_reg(), pick_reg(), 3'(f3 % 3)));
            endcase
        end
        bp_en = 1'b1;
        run_prog();
        bp_en = 1'b0;
        @(posedge clk);
        res_ready <= 1'b1;
        @(posedge clk);
    endtask

    task automatic test_throughput();
        arr_q.delete();
        sent_q.delete();
        for (int i = 0; i < 16; i++) begin
            emit(enc_i(12'(rand_bits(12)), 5'd0, 3'd0, 5'(i + 1)));
        end
        run_prog();
        // record is taken two edges after its instruction
        for (int i = 0; i < arr_q.size(); i++) begin
            check_bit("res_valid_o", (arr_q[i] - sent_q[i]) == 2, 1'b1);
        end
        for (int i = 1; i < arr_q.size(); i++) begin
            check_bit("res_valid_o", (arr_q[i] - arr_q[i - 1]) == 1, 1'b1);
        end
    endtask

    task automatic test_x0_nop();
        emit(enc_i(12'h123, 5'd5, 3'd0, 5'd0));
        emit(enc_u(20'(rand_bits(20)), 5'd0));
        emit(enc_r(7'h00, 5'd6, 5'd5, 3'd0, 5'd0));
        emit(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd16));
        emit(enc_i(12'h000, 5'd0, 3'd6, 5'd17));
        // load, jal, branch, system, fence
        emit({25'(rand_bits(25)), 7'b0000011});
        emit({25'(rand_bits(25)), 7'b1101111});
        emit({25'(rand_bits(25)), 7'b1100011});
        emit({25'(rand_bits(25)), 7'b1110011});
        emit({25'(rand_bits(25)), 7'b0001111});
        emit(enc_s(12'(rand_bits(12)), 5'd6, 5'd5, 3'b011));
        emit(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd18));
        run_prog();
        dump_regs();
    endtask

    initial begin
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        res_ready = 1'b1;
        bp_en = 1'b0;
        cycle_cnt = 0;
        in_flight = 0;
        lfsr_q = 32'h709d472c;
        for (int r = 0; r < NREGS; r++) begin
            shadow[r] = '0;
        end
        reset_dut();
        test_alu_ops();
        test_dependency();
        test_stores();
        test_backpressure();
        test_throughput();
        test_x0_nop();
        repeat (4) @(posedge clk);
        if (exp_q.size() == 0 && u_rv_ex_top.u_sva.n_fail == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            abort_run("records missing or an assertion failed at the end of the run");
        end
    end

    initial begin
        #(CLK_NS * (RESET_CYCLES + TEST_INSTRS * CYC_PER_INSTR));
        abort_run("timeout: the tests did not finish in the allowed time");
    end

endmodule

`default_nettype wire

/* tests/rv_ex_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_ex_sva (
    input wire                              clk_i,
    input wire                              rst_n_i,
    input wire                              res_valid_i,
    input wire                              res_ready_i,
    input wire rv_pipe_pkg::res_t           res_i,
    input wire                              wr_en_i,
    input wire [rv_isa_pkg::REG_AW-1:0]     wr_addr_i
);

    int n_fail = 0;

    // stalled record holds until taken
    a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        res_valid_i && !res_ready_i |=> res_valid_i && $stable(res_i))
    else begin
        $error("output record changed while stalled");
        n_fail++;
    end

    a_reset_quiet: assert property (@(posedge clk_i) !rst_n_i |-> !res_valid_i)
    else begin
        $error("res_valid_o high during reset");
        n_fail++;
    end

    a_no_x0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wr_en_i |-> wr_addr_i != '0)
    else begin
        $error("register write to x0");
        n_fail++;
    end

endmodule

bind rv_ex_top rv_ex_sva u_sva (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .res_valid_i (res_valid_o),
    .res_ready_i (res_ready_i),
    .res_i       (res_o),
    .wr_en_i     (rf_wr_en),
    .wr_addr_i   (rf_wr_addr)
);

`default_nettype wire

/* hdl/rv_ex_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_ex_top #(
    parameter int NREGS = 32
) (
    input  wire                           clk_i,
    input  wire                           rst_n_i,

    input  wire                           instr_valid_i,
    output logic                          instr_ready_o,
    input  wire [rv_isa_pkg::XLEN-1:0]    instr_i,

    output logic                          res_valid_o,
    input  wire                           res_ready_i,
    output rv_pipe_pkg::res_t             res_o
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic              dec_valid;
    logic              dec_ready;
    dec_t              dec_d;
    logic              dec_q_valid;
    logic              dec_q_ready;
    dec_t              dec_q;

    logic              ex_valid;
    logic              ex_ready;
    res_t              ex_res;
    logic              res_q_valid;
    logic              res_q_ready;
    res_t              res_q;

    logic [REG_AW-1:0] rf_addr_a;
    logic [REG_AW-1:0] rf_addr_b;
    logic [XLEN-1:0]   rf_data_a;
    logic [XLEN-1:0]   rf_data_b;
    logic              rf_wr_en;
    logic [REG_AW-1:0] rf_wr_addr;
    logic [XLEN-1:0]   rf_wr_data;
    fwd_t              fwd;

    rv_decode #(
        .NREGS (NREGS)
    ) u_decode (
        .instr_valid_i (instr_valid_i),
        .instr_ready_o (instr_ready_o),
        .instr_i       (instr_i),
        .rf_addr_a_o   (rf_addr_a),
        .rf_addr_b_o   (rf_addr_b),
        .rf_data_a_i   (rf_data_a),
        .rf_data_b_i   (rf_data_b),
        .dec_valid_o   (dec_valid),
        .dec_ready_i   (dec_ready),
        .dec_o         (dec_d)
    );

    pipe_reg #(
        .payload_t (dec_t)
    ) u_dec_reg (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (dec_valid),
        .in_ready_o  (dec_ready),
        .in_data_i   (dec_d),
        .out_valid_o (dec_q_valid),
        .out_ready_i (dec_q_ready),
        .out_data_o  (dec_q)
    );

    rv_execute u_execute (
        .dec_valid_i (dec_q_valid),
        .dec_ready_o (dec_q_ready),
        .dec_i       (dec_q),
        .fwd_i       (fwd),
        .res_valid_o (ex_valid),
        .res_ready_i (ex_ready),
        .res_o       (ex_res)
    );

    pipe_reg #(
        .payload_t (res_t)
    ) u_res_reg (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (ex_valid),
        .in_ready_o  (ex_ready),
        .in_data_i   (ex_res),
        .out_valid_o (res_q_valid),
        .out_ready_i (res_q_ready),
        .out_data_o  (res_q)
    );

    rv_result u_result (
        .res_valid_i  (res_q_valid),
        .res_ready_o  (res_q_ready),
        .res_i        (res_q),
        .res_valid_o  (res_valid_o),
        .res_ready_i  (res_ready_i),
        .res_o        (res_o),
        .rf_wr_en_o   (rf_wr_en),
        .rf_wr_addr_o (rf_wr_addr),
        .rf_wr_data_o (rf_wr_data),
        .fwd_o        (fwd)
    );

    reg_file #(
        .NREGS (NREGS)
    ) u_reg_file (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rd_addr_a_i (rf_addr_a),
        .rd_addr_b_i (rf_addr_b),
        .rd_data_a_o (rf_data_a),
        .rd_data_b_o (rf_data_b),
        .wr_en_i     (rf_wr_en),
        .wr_addr_i   (rf_wr_addr),
        .wr_data_i   (rf_wr_data)
    );

endmodule

`default_nettype wire

/* hdl/rv_result.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_result (
    input  wire                   res_valid_i,
    output logic                  res_ready_o,
    input  wire rv_pipe_pkg::res_t res_i,

    output logic                  res_valid_o,
    input  wire                   res_ready_i,
    output rv_pipe_pkg::res_t     res_o,

    output logic                              rf_wr_en_o,
    output logic [rv_isa_pkg::REG_AW-1:0]     rf_wr_addr_o,
    output logic [rv_isa_pkg::XLEN-1:0]       rf_wr_data_o,

    output rv_pipe_pkg::fwd_t     fwd_o
);

    import rv_pipe_pkg::*;

    logic take;
    logic writes_rd;

    assign res_valid_o = res_valid_i;
    assign res_ready_o = res_ready_i;
    assign res_o       = res_i;

    assign take      = res_valid_i && res_ready_i;
    assign writes_rd = res_i.kind == KIND_REG && res_i.rd != '0;

    // commit only on the output handshake
    assign rf_wr_en_o   = take && writes_rd;
    assign rf_wr_addr_o = res_i.rd;
    assign rf_wr_data_o = res_i.value;

    // held record is the newest result not yet in the register file
    assign fwd_o.valid = res_valid_i && writes_rd;
    assign fwd_o.rd    = res_i.rd;
    assign fwd_o.value = res_i.value;

endmodule

`default_nettype wire

/* hdl/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  wire                   dec_valid_i,
    output logic                  dec_ready_o,
    input  wire rv_pipe_pkg::dec_t dec_i,

    input  wire rv_pipe_pkg::fwd_t fwd_i,

    output logic                  res_valid_o,
    input  wire                   res_ready_i,
    output rv_pipe_pkg::res_t     res_o
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [XLEN-1:0]   op_a;
    logic [XLEN-1:0]   rs2_v;
    logic [XLEN-1:0]   op_b;
    logic [XLEN-1:0]   alu_y;
    logic [4:0]        shamt;
    logic [1:0]        offs;
    logic [1:0]        lane;
    logic [XLEN/8-1:0] be;

    // forward from the record waiting in front of writeback
    assign op_a  = (fwd_i.valid && fwd_i.rd == dec_i.rs1) ? fwd_i.value : dec_i.rs1_val;
    assign rs2_v = (fwd_i.valid && fwd_i.rd == dec_i.rs2) ? fwd_i.value : dec_i.rs2_val;
    assign op_b  = dec_i.use_imm ? dec_i.imm : rs2_v;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:    alu_y = op_a + op_b;
            ALU_SUB:    alu_y = op_a - op_b;
            ALU_SLL:    alu_y = op_a << shamt;
            ALU_SLT:    alu_y = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_y = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    alu_y = op_a ^ op_b;
            ALU_SRL:    alu_y = op_a >> shamt;
            ALU_SRA:    alu_y = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     alu_y = op_a | op_b;
            ALU_AND:    alu_y = op_a & op_b;
            ALU_PASS_B: alu_y = op_b;
            default:    alu_y = '0;
        endcase
    end

    assign offs = alu_y[1:0];

    // byte lanes from size and address offset
    always_comb begin
        case (dec_i.funct3)
            F3_SB: begin
                lane = offs;
                be   = 4'b0001 << offs;
            end
            F3_SH: begin
                lane = {offs[1], 1'b0};
                be   = 4'b0011 << {offs[1], 1'b0};
            end
            default: begin
                lane = 2'b00;
                be   = 4'b1111;
            end
        endcase
    end

    always_comb begin
        res_o         = '0;
        res_o.kind    = dec_i.kind;
        res_o.rd      = dec_i.rd;
        res_o.value   = alu_y;
        if (dec_i.kind == KIND_STORE) begin
            res_o.store_data = rs2_v << {lane, 3'b000};
            res_o.byte_en    = be;
        end
    end

    assign res_valid_o = dec_valid_i;
    assign dec_ready_o = res_ready_i;

endmodule

`default_nettype wire

/* hdl/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode #(
    parameter int NREGS = 32
) (
    input  wire                                instr_valid_i,
    output logic                               instr_ready_o,
    input  wire [rv_isa_pkg::XLEN-1:0]         instr_i,

    output logic [rv_isa_pkg::REG_AW-1:0]      rf_addr_a_o,
    output logic [rv_isa_pkg::REG_AW-1:0]      rf_addr_b_o,
    input  wire [rv_isa_pkg::XLEN-1:0]         rf_data_a_i,
    input  wire [rv_isa_pkg::XLEN-1:0]         rf_data_b_i,

    output logic                               dec_valid_o,
    input  wire                                dec_ready_i,
    output rv_pipe_pkg::dec_t                  dec_o
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_i_w;
    logic [XLEN-1:0] imm_s_w;
    logic [XLEN-1:0] imm_u_w;
    dec_t            dec_d;

    assign opcode  = instr_i[6:0];
    assign funct3  = instr_i[14:12];
    assign imm_i_w = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_w = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_u_w = {instr_i[31:12], 12'b0};

    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        dec_d        = '0;
        dec_d.kind   = KIND_NOP;
        dec_d.alu_op = ALU_ADD;
        dec_d.funct3 = funct3;
        case (opcode)
            OP_REG: begin
                dec_d.kind   = KIND_REG;
                dec_d.alu_op = alu_sel(funct3, instr_i[30]);
                dec_d.rd     = instr_i[11:7];
                dec_d.rs1    = instr_i[19:15];
                dec_d.rs2    = instr_i[24:20];
            end
            OP_IMM: begin
                // no subi, bit 30 only selects sra
                dec_d.kind    = KIND_REG;
                dec_d.alu_op  = alu_sel(funct3, instr_i[30] && funct3 == F3_SRL_SRA);
                dec_d.rd      = instr_i[11:7];
                dec_d.rs1     = instr_i[19:15];
                dec_d.imm     = imm_i_w;
                dec_d.use_imm = 1'b1;
            end
            OP_LUI: begin
                dec_d.kind    = KIND_REG;
                dec_d.alu_op  = ALU_PASS_B;
                dec_d.rd      = instr_i[11:7];
                dec_d.imm     = imm_u_w;
                dec_d.use_imm = 1'b1;
            end
            OP_STORE: begin
                if (funct3 == F3_SB || funct3 == F3_SH || funct3 == F3_SW) begin
                    dec_d.kind    = KIND_STORE;
                    dec_d.rs1     = instr_i[19:15];
                    dec_d.rs2     = instr_i[24:20];
                    dec_d.imm     = imm_s_w;
                    dec_d.use_imm = 1'b1;
                end
            end
            default: ;
        endcase
        // registers beyond NREGS do not exist
        if (int'(dec_d.rd) >= NREGS || int'(dec_d.rs1) >= NREGS ||
            int'(dec_d.rs2) >= NREGS) begin
            dec_d      = '0;
            dec_d.kind = KIND_NOP;
        end
    end

    assign rf_addr_a_o = dec_d.rs1;
    assign rf_addr_b_o = dec_d.rs2;

    always_comb begin
        dec_o         = dec_d;
        dec_o.rs1_val = rf_data_a_i;
        dec_o.rs2_val = rf_data_b_i;
    end

    assign dec_valid_o   = instr_valid_i;
    assign instr_ready_o = dec_ready_i;

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
    parameter int NREGS = 32
) (
    input  wire                                clk_i,
    input  wire                                rst_n_i,

    input  wire [rv_isa_pkg::REG_AW-1:0]       rd_addr_a_i,
    input  wire [rv_isa_pkg::REG_AW-1:0]       rd_addr_b_i,
    output logic [rv_isa_pkg::XLEN-1:0]        rd_data_a_o,
    output logic [rv_isa_pkg::XLEN-1:0]        rd_data_b_o,

    input  wire                                wr_en_i,
    input  wire [rv_isa_pkg::REG_AW-1:0]       wr_addr_i,
    input  wire [rv_isa_pkg::XLEN-1:0]         wr_data_i
);

    import rv_isa_pkg::*;

    localparam int AW = $clog2(NREGS);

    logic [XLEN-1:0] regs_q [NREGS];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && wr_addr_i != '0) begin
            regs_q[wr_addr_i[AW-1:0]] <= wr_data_i;
        end
    end

    // x0 first, then the write of this cycle, then the array
    function automatic logic [XLEN-1:0] read_port(input logic [REG_AW-1:0] addr);
        logic [XLEN-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (wr_en_i && wr_addr_i == addr) begin
            data = wr_data_i;
        end else begin
            data = regs_q[addr[AW-1:0]];
        end
        return data;
    endfunction

    assign rd_data_a_o = read_port(rd_addr_a_i);
    assign rd_data_b_o = read_port(rd_addr_b_i);

endmodule

`default_nettype wire

/* hdl/pipe_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  wire        clk_i,
    input  wire        rst_n_i,

    input  wire        in_valid_i,
    output logic       in_ready_o,
    input  wire        payload_t in_data_i,

    output logic       out_valid_o,
    input  wire        out_ready_i,
    output payload_t   out_data_o
);

    logic     full_q;
    payload_t data_q;

    // free when empty or the held entry leaves this cycle
    assign in_ready_o  = !full_q || out_ready_i;
    assign out_valid_o = full_q;
    assign out_data_o  = data_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            full_q <= 1'b0;
        end else if (in_ready_o) begin
            full_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_data_i;
        end
    end

endmodule

`default_nettype wire

/* hdl/rv_pipe_pkg.sv */
`default_nettype none

package rv_pipe_pkg;

    typedef enum logic [1:0] {
        KIND_REG   = 2'd0,
        KIND_STORE = 2'd1,
        KIND_NOP   = 2'd2
    } kind_e;

    // decoded instruction with its register operands
    typedef struct packed {
        kind_e                             kind;
        rv_isa_pkg::alu_op_e               alu_op;
        logic [rv_isa_pkg::REG_AW-1:0]     rd;
        logic [rv_isa_pkg::REG_AW-1:0]     rs1;
        logic [rv_isa_pkg::REG_AW-1:0]     rs2;
        logic [rv_isa_pkg::XLEN-1:0]       rs1_val;
        logic [rv_isa_pkg::XLEN-1:0]       rs2_val;
        logic [rv_isa_pkg::XLEN-1:0]       imm;
        logic                              use_imm;
        logic [2:0]                        funct3;
    } dec_t;

    // one record per instruction
    typedef struct packed {
        kind_e                             kind;
        logic [rv_isa_pkg::REG_AW-1:0]     rd;
        // alu result, address for stores
        logic [rv_isa_pkg::XLEN-1:0]       value;
        logic [rv_isa_pkg::XLEN-1:0]       store_data;
        logic [rv_isa_pkg::XLEN/8-1:0]     byte_en;
    } res_t;

    typedef struct packed {
        logic                              valid;
        logic [rv_isa_pkg::REG_AW-1:0]     rd;
        logic [rv_isa_pkg::XLEN-1:0]       value;
    } fwd_t;

endpackage

`default_nettype wire

/* hdl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // data path width
    localparam int XLEN   = 32;
    // architectural register address width
    localparam int REG_AW = 5;

    // major opcodes
    localparam logic [6:0] OP_REG   = 7'b0110011;
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    // funct3 for OP_REG and OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for stores
    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        // operand b straight through, for lui
        ALU_PASS_B = 4'd10
    } alu_op_e;

endpackage

`default_nettype wire
